// File: hw/cache_geom_pkg.sv
// Cache line geometry
package cache_geom_pkg;

    // One data word.
    localparam int WORD_WIDTH = 32;

    // Words held in one cache line.
    localparam int WORDS_PER_LINE = 4;

    // Full line as stored in a data SRAM row.
    localparam int LINE_WIDTH = WORD_WIDTH * WORDS_PER_LINE;

    // Word index field at the bottom of the address.
    localparam int OFFSET_WIDTH = 2;

    // Byte enables per word.
    localparam int BE_WIDTH = WORD_WIDTH / 8;

endpackage

// File: hw/cache_op_pkg.sv
// Cache request operations
package cache_op_pkg;

    // Operation codes on the request port.
    typedef enum logic [1:0] {
        OP_READ  = 2'd0, // Lookup in all ways.
        OP_WRITE = 2'd1, // Partial word store into one way.
        OP_FILL  = 2'd2, // Tag and full line into one way.
        OP_INVAL = 2'd3  // Clear the valid bit of one way.
    } cache_op_e;

endpackage

// File: hw/cache_sram.sv
// Single-port masked SRAM
module cache_sram #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk_i,
    input  logic                  cs_i,
    input  logic                  we_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic [DATA_WIDTH-1:0] wmask_i,
    output logic [DATA_WIDTH-1:0] rdata_o
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Write and read share the port, chip select gates both.
    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                // Only masked bits change.
                mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
            end else begin
                rdata_o <= mem[addr_i]; // One cycle read latency.
            end
        end
    end

endmodule

// File: hw/cache_req_issue.sv
// Cache request issuer
module cache_req_issue
    import cache_geom_pkg::*;
    import cache_op_pkg::*;
#(
    parameter int NWAYS     = 4,
    parameter int SET_WIDTH = 4,
    parameter int TAG_WIDTH = 8
) (
    input  logic                                        clk_i,
    input  logic                                        reset_i,
    input  logic                                        req_valid_i,
    input  cache_op_e                                   req_op_i,
    input  logic [TAG_WIDTH+SET_WIDTH+OFFSET_WIDTH-1:0] req_addr_i,
    input  logic [$clog2(NWAYS)-1:0]                    req_way_i,
    input  logic [BE_WIDTH-1:0]                         req_be_i,
    input  logic [WORD_WIDTH-1:0]                       req_wdata_i,
    input  logic [LINE_WIDTH-1:0]                       req_line_i,
    output logic [NWAYS-1:0]                            dir_cs_o,
    output logic [NWAYS-1:0]                            dir_we_o,
    output logic [NWAYS-1:0]                            valid_set_o,
    output logic [NWAYS-1:0]                            valid_clr_o,
    output logic [NWAYS-1:0]                            data_cs_o,
    output logic [NWAYS-1:0]                            data_we_o,
    output logic [SET_WIDTH-1:0]                        dir_addr_o,
    output logic [TAG_WIDTH-1:0]                        dir_wtag_o,
    output logic [LINE_WIDTH-1:0]                       data_wline_o,
    output logic [WORDS_PER_LINE*BE_WIDTH-1:0]          data_wbe_o,
    output logic                                        lookup_valid_o,
    output logic [TAG_WIDTH-1:0]                        lookup_tag_o,
    output logic [OFFSET_WIDTH-1:0]                     lookup_offset_o
);

    localparam int ADDR_WIDTH = TAG_WIDTH + SET_WIDTH + OFFSET_WIDTH;
    localparam int WAY_WIDTH  = $clog2(NWAYS);

    logic                    req_valid_q;
    cache_op_e               req_op_q;
    logic [ADDR_WIDTH-1:0]   req_addr_q;
    logic [WAY_WIDTH-1:0]    req_way_q;
    logic [BE_WIDTH-1:0]     req_be_q;
    logic [WORD_WIDTH-1:0]   req_wdata_q;
    logic [LINE_WIDTH-1:0]   req_line_q;
    logic [TAG_WIDTH-1:0]    req_tag;
    logic [SET_WIDTH-1:0]    req_set;
    logic [OFFSET_WIDTH-1:0] req_offset;
    logic [NWAYS-1:0]        way_onehot;
    logic                    is_read;
    logic                    is_write;
    logic                    is_fill;
    logic                    is_inval;

    // Request register, SRAMs see the controls one edge later.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        req_op_q    <= req_op_i;
        req_addr_q  <= req_addr_i;
        req_way_q   <= req_way_i;
        req_be_q    <= req_be_i;
        req_wdata_q <= req_wdata_i;
        req_line_q  <= req_line_i;
    end

    // Address fields, tag on top and word offset at the bottom.
    assign req_tag    = req_addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign req_set    = req_addr_q[OFFSET_WIDTH +: SET_WIDTH];
    assign req_offset = req_addr_q[OFFSET_WIDTH-1:0];

    assign is_read  = req_valid_q && (req_op_q == OP_READ);
    assign is_write = req_valid_q && (req_op_q == OP_WRITE);
    assign is_fill  = req_valid_q && (req_op_q == OP_FILL);
    assign is_inval = req_valid_q && (req_op_q == OP_INVAL);

    assign way_onehot = NWAYS'(1) << req_way_q;

    // A lookup enables every way, updates touch only the chosen one.
    assign dir_cs_o    = {NWAYS{is_read}} | ({NWAYS{is_fill}} & way_onehot);
    assign dir_we_o    = {NWAYS{is_fill}} & way_onehot;
    assign valid_set_o = {NWAYS{is_fill}} & way_onehot;
    assign valid_clr_o = {NWAYS{is_inval}} & way_onehot;
    assign data_cs_o   = {NWAYS{is_read}} | ({NWAYS{is_fill | is_write}} & way_onehot);
    assign data_we_o   = {NWAYS{is_fill | is_write}} & way_onehot;

    assign dir_addr_o   = req_set;
    assign dir_wtag_o   = req_tag;
    assign data_wline_o = is_fill ? req_line_q : {WORDS_PER_LINE{req_wdata_q}}; // Store word replicated.

    // Byte enables across the line.
    always_comb begin
        if (is_fill) begin
            data_wbe_o = '1;
        end else begin
            data_wbe_o = '0;
            data_wbe_o[req_offset*BE_WIDTH +: BE_WIDTH] = req_be_q;
        end
    end

    // Tag and offset follow the SRAM read by one cycle.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            lookup_valid_o <= 1'b0;
        end else begin
            lookup_valid_o <= is_read;
        end
    end

    always_ff @(posedge clk_i) begin
        lookup_tag_o    <= req_tag;
        lookup_offset_o <= req_offset;
    end

    // Updates must address a way that exists in the array.
    way_in_range_a: assert property (@(posedge clk_i) disable iff (reset_i)
        req_valid_i && (req_op_i != OP_READ) |-> (int'(req_way_i) < NWAYS));

endmodule

// File: hw/cache_memarray.sv
// Cache directory and data arrays
module cache_memarray
    import cache_geom_pkg::*;
#(
    parameter int NWAYS     = 4,
    parameter int SET_WIDTH = 4,
    parameter int TAG_WIDTH = 8
) (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic [NWAYS-1:0]                     dir_cs_i,
    input  logic [NWAYS-1:0]                     dir_we_i,
    input  logic [NWAYS-1:0]                     valid_set_i,
    input  logic [NWAYS-1:0]                     valid_clr_i,
    input  logic [NWAYS-1:0]                     data_cs_i,
    input  logic [NWAYS-1:0]                     data_we_i,
    input  logic [SET_WIDTH-1:0]                 dir_addr_i,
    input  logic [TAG_WIDTH-1:0]                 dir_wtag_i,
    input  logic [LINE_WIDTH-1:0]                data_wline_i,
    input  logic [WORDS_PER_LINE*BE_WIDTH-1:0]   data_wbe_i,
    output logic [NWAYS-1:0][TAG_WIDTH-1:0]      rd_tag_o,
    output logic [NWAYS-1:0]                     rd_valid_o,
    output logic [NWAYS-1:0][LINE_WIDTH-1:0]     rd_line_o
);

    localparam int NSETS = 2 ** SET_WIDTH;

    logic [LINE_WIDTH-1:0] data_wmask;
    logic [NWAYS-1:0]      valid_q [NSETS];

    // Each byte enable covers eight mask bits.
    always_comb begin
        for (int b = 0; b < WORDS_PER_LINE * BE_WIDTH; b++) begin
            data_wmask[8*b +: 8] = {8{data_wbe_i[b]}};
        end
    end

    for (genvar w = 0; w < NWAYS; w++) begin : g_way
        cache_sram #(
            .DATA_WIDTH (TAG_WIDTH),
            .ADDR_WIDTH (SET_WIDTH)
        ) u_tag_sram (
            .clk_i   (clk_i),
            .cs_i    (dir_cs_i[w]),
            .we_i    (dir_we_i[w]),
            .addr_i  (dir_addr_i),
            .wdata_i (dir_wtag_i),
            .wmask_i ({TAG_WIDTH{1'b1}}), // Tags are written whole.
            .rdata_o (rd_tag_o[w])
        );

        // Data rows are indexed by the same set as the directory.
        cache_sram #(
            .DATA_WIDTH (LINE_WIDTH),
            .ADDR_WIDTH (SET_WIDTH)
        ) u_data_sram (
            .clk_i   (clk_i),
            .cs_i    (data_cs_i[w]),
            .we_i    (data_we_i[w]),
            .addr_i  (dir_addr_i),
            .wdata_i (data_wline_i),
            .wmask_i (data_wmask),
            .rdata_o (rd_line_o[w])
        );
    end

    // Valid bits live in flops so that reset can clear them.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int s = 0; s < NSETS; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            valid_q[dir_addr_i] <= (valid_q[dir_addr_i] | valid_set_i) & ~valid_clr_i;
        end
    end

    // Registered like the tag SRAM output.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_valid_o <= '0;
        end else begin
            for (int w = 0; w < NWAYS; w++) begin
                if (dir_cs_i[w]) rd_valid_o[w] <= valid_q[dir_addr_i][w];
            end
        end
    end

    // A way is never set and cleared in the same cycle.
    valid_excl_a: assert property (@(posedge clk_i) disable iff (reset_i)
        (valid_set_i & valid_clr_i) == '0);

endmodule

// File: hw/cache_hit_select.sv
// Cache hit selection
module cache_hit_select
    import cache_geom_pkg::*;
#(
    parameter int NWAYS     = 4,
    parameter int SET_WIDTH = 4,
    parameter int TAG_WIDTH = 8
) (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             lookup_valid_i,
    input  logic [TAG_WIDTH-1:0]             lookup_tag_i,
    input  logic [OFFSET_WIDTH-1:0]          lookup_offset_i,
    input  logic [NWAYS-1:0][TAG_WIDTH-1:0]  rd_tag_i,
    input  logic [NWAYS-1:0]                 rd_valid_i,
    input  logic [NWAYS-1:0][LINE_WIDTH-1:0] rd_line_i,
    output logic                             rsp_valid_o,
    output logic                             rsp_hit_o,
    output logic [$clog2(NWAYS)-1:0]         rsp_way_o,
    output logic [WORD_WIDTH-1:0]            rsp_data_o
);

    localparam int WAY_WIDTH = $clog2(NWAYS);

    logic [NWAYS-1:0]      hit_vec;
    logic [WAY_WIDTH-1:0]  hit_way;
    logic [LINE_WIDTH-1:0] hit_line;
    logic [WORD_WIDTH-1:0] hit_word;

    // Valid and matching tag per way.
    always_comb begin
        for (int w = 0; w < NWAYS; w++) begin
            hit_vec[w] = lookup_valid_i && rd_valid_i[w] && (rd_tag_i[w] == lookup_tag_i);
        end
    end

    // And-or select leaves way and data at zero on a miss.
    always_comb begin
        hit_way  = '0;
        hit_line = '0;
        for (int w = 0; w < NWAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way  = hit_way | WAY_WIDTH'(w);
                hit_line = hit_line | rd_line_i[w];
            end
        end
    end

    assign hit_word = hit_line[lookup_offset_i*WORD_WIDTH +: WORD_WIDTH]; // Word by offset.

    // Response register.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_o <= 1'b0;
            rsp_hit_o   <= 1'b0;
        end else begin
            rsp_valid_o <= lookup_valid_i;
            rsp_hit_o   <= |hit_vec;
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_way_o  <= hit_way;
        rsp_data_o <= hit_word;
    end

    // A tag lives in one way of a set at most.
    single_hit_a: assert property (@(posedge clk_i) disable iff (reset_i)
        lookup_valid_i |-> $onehot0(hit_vec));

endmodule

// File: hw/cache_top.sv
// Cache storage core
module cache_top
    import cache_geom_pkg::*;
    import cache_op_pkg::*;
#(
    parameter int NWAYS     = 4,
    parameter int SET_WIDTH = 4,
    parameter int TAG_WIDTH = 8
) (
    input  logic                                        clk_i,
    input  logic                                        reset_i,
    input  logic                                        req_valid_i,
    input  cache_op_e                                   req_op_i,
    input  logic [TAG_WIDTH+SET_WIDTH+OFFSET_WIDTH-1:0] req_addr_i,
    input  logic [$clog2(NWAYS)-1:0]                    req_way_i,
    input  logic [BE_WIDTH-1:0]                         req_be_i,
    input  logic [WORD_WIDTH-1:0]                       req_wdata_i,
    input  logic [LINE_WIDTH-1:0]                       req_line_i,
    output logic                                        rsp_valid_o,
    output logic                                        rsp_hit_o,
    output logic [$clog2(NWAYS)-1:0]                    rsp_way_o,
    output logic [WORD_WIDTH-1:0]                       rsp_data_o
);

    // Issuer to memory array.
    logic [NWAYS-1:0]                   dir_cs;
    logic [NWAYS-1:0]                   dir_we;
    logic [NWAYS-1:0]                   valid_set;
    logic [NWAYS-1:0]                   valid_clr;
    logic [NWAYS-1:0]                   data_cs;
    logic [NWAYS-1:0]                   data_we;
    logic [SET_WIDTH-1:0]               dir_addr;
    logic [TAG_WIDTH-1:0]               dir_wtag;
    logic [LINE_WIDTH-1:0]              data_wline;
    logic [WORDS_PER_LINE*BE_WIDTH-1:0] data_wbe;

    // Issuer to hit selector.
    logic                               lookup_valid;
    logic [TAG_WIDTH-1:0]               lookup_tag;
    logic [OFFSET_WIDTH-1:0]            lookup_offset;

    // Memory array to hit selector.
    logic [NWAYS-1:0][TAG_WIDTH-1:0]    rd_tag;
    logic [NWAYS-1:0]                   rd_valid;
    logic [NWAYS-1:0][LINE_WIDTH-1:0]   rd_line;

    cache_req_issue #(
        .NWAYS     (NWAYS),
        .SET_WIDTH (SET_WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_issue (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .req_valid_i     (req_valid_i),
        .req_op_i        (req_op_i),
        .req_addr_i      (req_addr_i),
        .req_way_i       (req_way_i),
        .req_be_i        (req_be_i),
        .req_wdata_i     (req_wdata_i),
        .req_line_i      (req_line_i),
        .dir_cs_o        (dir_cs),
        .dir_we_o        (dir_we),
        .valid_set_o     (valid_set),
        .valid_clr_o     (valid_clr),
        .data_cs_o       (data_cs),
        .data_we_o       (data_we),
        .dir_addr_o      (dir_addr),
        .dir_wtag_o      (dir_wtag),
        .data_wline_o    (data_wline),
        .data_wbe_o      (data_wbe),
        .lookup_valid_o  (lookup_valid),
        .lookup_tag_o    (lookup_tag),
        .lookup_offset_o (lookup_offset)
    );

    cache_memarray #(
        .NWAYS     (NWAYS),
        .SET_WIDTH (SET_WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_memarray (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .dir_cs_i     (dir_cs),
        .dir_we_i     (dir_we),
        .valid_set_i  (valid_set),
        .valid_clr_i  (valid_clr),
        .data_cs_i    (data_cs),
        .data_we_i    (data_we),
        .dir_addr_i   (dir_addr),
        .dir_wtag_i   (dir_wtag),
        .data_wline_i (data_wline),
        .data_wbe_i   (data_wbe),
        .rd_tag_o     (rd_tag),
        .rd_valid_o   (rd_valid),
        .rd_line_o    (rd_line)
    );

    cache_hit_select #(
        .NWAYS     (NWAYS),
        .SET_WIDTH (SET_WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_hit_select (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .lookup_valid_i  (lookup_valid),
        .lookup_tag_i    (lookup_tag),
        .lookup_offset_i (lookup_offset),
        .rd_tag_i        (rd_tag),
        .rd_valid_i      (rd_valid),
        .rd_line_i       (rd_line),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_hit_o       (rsp_hit_o),
        .rsp_way_o       (rsp_way_o),
        .rsp_data_o      (rsp_data_o)
    );

endmodule

// File: test/cache_tb_model.svh
// Cache reference model
`ifndef CACHE_TB_MODEL_SVH
`define CACHE_TB_MODEL_SVH

logic [TAG_WIDTH-1:0]  model_tag   [NSETS][NWAYS];
logic                  model_valid [NSETS][NWAYS];
logic [LINE_WIDTH-1:0] model_line  [NSETS][NWAYS];
logic [31:0]           lcg_state = 32'd84420;

// Linear congruential generator.
function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic int rand_below(input int n);
    return int'((rand_word() >> 16) % n); // Upper bits are the better ones.
endfunction

function automatic logic [LINE_WIDTH-1:0] rand_line();
    return {rand_word(), rand_word(), rand_word(), rand_word()};
endfunction

function automatic void model_clear();
    for (int s = 0; s < NSETS; s++) begin
        for (int w = 0; w < NWAYS; w++) begin
            model_valid[s][w] = 1'b0;
            model_tag[s][w]   = '0;
        end
    end
endfunction

function automatic void model_fill(input int set, input int way,
                                   input logic [TAG_WIDTH-1:0] tag,
                                   input logic [LINE_WIDTH-1:0] line);
    model_tag[set][way]   = tag;
    model_line[set][way]  = line;
    model_valid[set][way] = 1'b1;
endfunction

// Byte merge into one word of the line.
function automatic void model_write(input int set, input int way, input int offset,
                                    input logic [BE_WIDTH-1:0] be,
                                    input logic [WORD_WIDTH-1:0] wdata);
    for (int b = 0; b < BE_WIDTH; b++) begin
        if (be[b]) begin
            model_line[set][way][offset*WORD_WIDTH + 8*b +: 8] = wdata[8*b +: 8];
        end
    end
endfunction

function automatic void model_inval(input int set, input int way);
    model_valid[set][way] = 1'b0;
endfunction

// Expected response as {hit, way, word}, zero way and word on a miss.
function automatic logic [EXP_WIDTH-1:0] model_lookup(input int set,
                                                      input logic [TAG_WIDTH-1:0] tag,
                                                      input int offset);
    logic                  hit;
    logic [WAY_WIDTH-1:0]  hit_way;
    logic [WORD_WIDTH-1:0] word;
    hit     = 1'b0;
    hit_way = '0;
    word    = '0;
    for (int w = 0; w < NWAYS; w++) begin
        if (model_valid[set][w] && model_tag[set][w] == tag) begin
            hit     = 1'b1;
            hit_way = WAY_WIDTH'(w);
            word    = model_line[set][w][offset*WORD_WIDTH +: WORD_WIDTH];
        end
    end
    return {hit, hit_way, word};
endfunction

// Random tag that no other valid way of the set holds.
function automatic logic [TAG_WIDTH-1:0] free_tag(input int set, input int way);
    logic [TAG_WIDTH-1:0] tag;
    logic                 taken;
    do begin
        tag   = TAG_WIDTH'(rand_word() >> 20);
        taken = 1'b0;
        for (int w = 0; w < NWAYS; w++) begin
            if (w != way && model_valid[set][w] && model_tag[set][w] == tag) begin
                taken = 1'b1;
            end
        end
    end while (taken);
    return tag;
endfunction

`endif

// File: test/cache_tb.sv
// Cache storage core testbench
module cache_tb
    import cache_geom_pkg::*;
    import cache_op_pkg::*;
();

    localparam int NWAYS         = 4;
    localparam int SET_WIDTH     = 4;
    localparam int TAG_WIDTH     = 8;
    localparam int NSETS         = 2 ** SET_WIDTH;
    localparam int WAY_WIDTH     = $clog2(NWAYS);
    localparam int ADDR_WIDTH    = TAG_WIDTH + SET_WIDTH + OFFSET_WIDTH;
    localparam int EXP_WIDTH     = 1 + WAY_WIDTH + WORD_WIDTH;
    localparam int N_MIX         = 48;
    localparam int N_REQUESTS    = NSETS + 4 * 5 + 8 * 2 + 2 * 7 + N_MIX;
    localparam int WATCHDOG_TIME = N_REQUESTS * 10 + 500;

    logic                  clk_i;
    logic                  reset_i;
    logic                  req_valid_i;
    cache_op_e             req_op_i;
    logic [ADDR_WIDTH-1:0] req_addr_i;
    logic [WAY_WIDTH-1:0]  req_way_i;
    logic [BE_WIDTH-1:0]   req_be_i;
    logic [WORD_WIDTH-1:0] req_wdata_i;
    logic [LINE_WIDTH-1:0] req_line_i;
    logic                  rsp_valid_o;
    logic                  rsp_hit_o;
    logic [WAY_WIDTH-1:0]  rsp_way_o;
    logic [WORD_WIDTH-1:0] rsp_data_o;

    logic [EXP_WIDTH-1:0]  exp_q [$];
    logic [2:0]            read_pipe;
    logic                  chk_rsp = 1'b0;
    logic                  got_valid = 1'b0;
    logic                  exp_valid = 1'b0;
    logic                  got_hit, exp_hit;
    logic [WAY_WIDTH-1:0]  got_way, exp_way;
    logic [WORD_WIDTH-1:0] got_data, exp_data;
    int                    errors = 0;
    int                    test_errors = 0;
    int                    checks = 0;

    `include "cache_tb_model.svh"

    cache_top #(
        .NWAYS     (NWAYS),
        .SET_WIDTH (SET_WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_way_i   (req_way_i),
        .req_be_i    (req_be_i),
        .req_wdata_i (req_wdata_i),
        .req_line_i  (req_line_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_hit_o   (rsp_hit_o),
        .rsp_way_o   (rsp_way_o),
        .rsp_data_o  (rsp_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout after %0d time units with responses still pending", WATCHDOG_TIME);
        $display("Test failed");
        $finish;
    end

    // Reads seen by the DUT, aged to line up with the response.
    always @(posedge clk_i) begin
        if (reset_i) begin
            read_pipe <= '0;
        end else begin
            read_pipe <= {read_pipe[1:0], req_valid_i && (req_op_i == OP_READ)};
        end
    end

    // Response capture in the middle of the cycle.
    always @(negedge clk_i) begin
        chk_rsp   = 1'b0;
        got_valid = reset_i ? 1'b0 : rsp_valid_o;
        exp_valid = reset_i ? 1'b0 : read_pipe[2];
        if (!reset_i && rsp_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Response arrived with no READ pending");
                errors++;
            end else begin
                {exp_hit, exp_way, exp_data} = exp_q.pop_front();
                got_hit  = rsp_hit_o;
                got_way  = rsp_way_o;
                got_data = rsp_data_o;
                chk_rsp  = 1'b1;
                checks++;
            end
        end
    end

    rsp_valid_a: assert property (@(posedge clk_i) disable iff (reset_i) got_valid == exp_valid)
        else begin
            $display("FAIL rsp_valid_o got %h expected %h", got_valid, exp_valid);
            errors++;
        end

    rsp_hit_a: assert property (@(posedge clk_i) disable iff (reset_i)
        chk_rsp |-> got_hit == exp_hit)
        else begin
            $display("FAIL rsp_hit_o got %h expected %h", got_hit, exp_hit);
            errors++;
        end

    rsp_way_a: assert property (@(posedge clk_i) disable iff (reset_i)
        chk_rsp |-> got_way == exp_way)
        else begin
            $display("FAIL rsp_way_o got %h expected %h", got_way, exp_way);
            errors++;
        end

    rsp_data_a: assert property (@(posedge clk_i) disable iff (reset_i)
        chk_rsp |-> got_data == exp_data)
        else begin
            $display("FAIL rsp_data_o got %h expected %h", got_data, exp_data);
            errors++;
        end

    // One request per falling edge; the model follows in request order.
    task automatic send(input cache_op_e op, input int set, input int way,
                        input logic [TAG_WIDTH-1:0] tag, input int offset,
                        input logic [BE_WIDTH-1:0] be, input logic [WORD_WIDTH-1:0] wdata,
                        input logic [LINE_WIDTH-1:0] line);
        @(negedge clk_i);
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_addr_i  = {tag, SET_WIDTH'(set), OFFSET_WIDTH'(offset)};
        req_way_i   = WAY_WIDTH'(way);
        req_be_i    = be;
        req_wdata_i = wdata;
        req_line_i  = line;
        case (op)
            OP_READ:  exp_q.push_back(model_lookup(set, tag, offset));
            OP_FILL:  model_fill(set, way, tag, line);
            OP_WRITE: model_write(set, way, offset, be, wdata);
            default:  model_inval(set, way);
        endcase
    endtask

    task automatic finish_test(input string name);
        @(negedge clk_i);
        req_valid_i = 1'b0;
        while (exp_q.size() != 0) @(negedge clk_i);
        @(posedge clk_i); // Last capture gets checked here.
        @(negedge clk_i);
        $display("%-13s finished, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic test_reset_miss();
        for (int s = 0; s < NSETS; s++) begin
            send(OP_READ, s, 0, TAG_WIDTH'(rand_word() >> 24), rand_below(WORDS_PER_LINE),
                 '0, '0, '0);
        end
        finish_test("reset_miss");
    endtask

    task automatic test_fill_read();
        int                   set;
        int                   way;
        logic [TAG_WIDTH-1:0] tag;
        repeat (4) begin
            set = rand_below(NSETS);
            way = rand_below(NWAYS);
            tag = free_tag(set, way);
            send(OP_FILL, set, way, tag, 0, '0, '0, rand_line());
            for (int o = 0; o < WORDS_PER_LINE; o++) begin
                send(OP_READ, set, 0, tag, o, '0, '0, '0);
            end
        end
        finish_test("fill_read");
    endtask

    task automatic test_write_merge();
        int                  set;
        int                  way;
        int                  offset;
        logic [BE_WIDTH-1:0] be;
        repeat (8) begin
            do begin
                set = rand_below(NSETS);
                way = rand_below(NWAYS);
            end while (!model_valid[set][way]);
            offset = rand_below(WORDS_PER_LINE);
            be     = BE_WIDTH'(rand_below(14) + 1); // Never none and never all.
            send(OP_WRITE, set, way, model_tag[set][way], offset, be, rand_word(), '0);
            send(OP_READ, set, 0, model_tag[set][way], offset, '0, '0, '0);
        end
        finish_test("write_merge");
    endtask

    task automatic test_fill_inval();
        int                   set;
        int                   way_a;
        int                   way_b;
        logic [TAG_WIDTH-1:0] tag_a;
        logic [TAG_WIDTH-1:0] tag_b;
        repeat (2) begin
            set   = rand_below(NSETS);
            way_a = rand_below(NWAYS);
            way_b = (way_a + 1 + rand_below(NWAYS - 1)) % NWAYS;
            tag_a = free_tag(set, way_a);
            send(OP_FILL, set, way_a, tag_a, 0, '0, '0, rand_line());
            tag_b = free_tag(set, way_b);
            send(OP_FILL, set, way_b, tag_b, 0, '0, '0, rand_line());
            send(OP_READ, set, 0, tag_a, rand_below(WORDS_PER_LINE), '0, '0, '0);
            send(OP_READ, set, 0, tag_b, rand_below(WORDS_PER_LINE), '0, '0, '0);
            send(OP_INVAL, set, way_a, tag_a, 0, '0, '0, '0);
            send(OP_READ, set, 0, tag_a, rand_below(WORDS_PER_LINE), '0, '0, '0);
            send(OP_READ, set, 0, tag_b, rand_below(WORDS_PER_LINE), '0, '0, '0);
        end
        finish_test("fill_inval");
    endtask

    // Half reads, the rest fills, writes and invalidates, all back to back.
    task automatic test_mixed_stream();
        int                   set;
        int                   way;
        int                   kind;
        int                   offset;
        logic [TAG_WIDTH-1:0] tag;
        for (int i = 0; i < N_MIX; i++) begin
            set    = rand_below(NSETS);
            way    = rand_below(NWAYS);
            kind   = rand_below(8);
            offset = rand_below(WORDS_PER_LINE);
            if (kind == 0 || kind == 3) begin
                send(OP_FILL, set, way, free_tag(set, way), 0, '0, '0, rand_line());
            end else if (kind == 1 && model_valid[set][way]) begin
                send(OP_WRITE, set, way, model_tag[set][way], offset,
                     BE_WIDTH'(rand_below(16)), rand_word(), '0);
            end else if (kind == 2) begin
                send(OP_INVAL, set, way, model_tag[set][way], 0, '0, '0, '0);
            end else begin
                tag = kind[0] ? model_tag[set][way] : TAG_WIDTH'(rand_word() >> 24);
                send(OP_READ, set, 0, tag, offset, '0, '0, '0);
            end
        end
        finish_test("mixed_stream");
    endtask

    initial begin
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_op_i    = OP_READ;
        req_addr_i  = '0;
        req_way_i   = '0;
        req_be_i    = '0;
        req_wdata_i = '0;
        req_line_i  = '0;
        model_clear();
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        test_reset_miss();
        test_fill_read();
        test_write_merge();
        test_fill_inval();
        test_mixed_stream();

        $display("Summary: 5 tests, %0d responses checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+test
hw/cache_geom_pkg.sv
hw/cache_op_pkg.sv
hw/cache_sram.sv
hw/cache_req_issue.sv
hw/cache_memarray.sv
hw/cache_hit_select.sv
hw/cache_top.sv
test/cache_tb.sv
